// File: common/gac_pkg.sv
// shared definitions for the action stage
// widths, word field positions, action opcodes and the register map
// used by the RTL and by the testbench
// multi-bit fields are given by their lowest bit plus a width constant

package gac_pkg;

	typedef logic [133:0] pkt_word_t;
	typedef logic [127:0] md_word_t;
	typedef logic [31:0]  act_entry_t;
	typedef logic [7:0]   mid_t;
	typedef logic [5:0]   port_t;

	// two-bit word flag at the top of each packet word
	localparam int PKT_FLAG_HI = 133;
	localparam int PKT_FLAG_LO = 132;
	localparam logic [1:0] FLAG_START = 2'b01;
	localparam logic [1:0] FLAG_END   = 2'b10;

	// ************************************************************************
	// field positions, same in the first packet word and in the metadata
	// ************************************************************************
	localparam int F_SRC     = 127;
	localparam int F_DES     = 126;
	localparam int F_INPORT  = 120;   // 125..120
	localparam int F_OUTTYPE = 118;   // 119..118
	localparam int F_OUTPORT = 112;   // 117..112
	localparam int F_PRIO    = 109;   // 111..109
	localparam int F_DISC    = 108;
	localparam int F_DMID    = 80;    // 87..80
	localparam int F_INDEX   = 50;    // 57..50

	localparam int W_PORT    = 6;
	localparam int W_OUTTYPE = 2;
	localparam int W_PRIO    = 3;
	localparam int W_MID     = 8;
	localparam int W_INDEX   = 8;

	// action table entry
	localparam int E_OP   = 28;   // 31..28
	localparam int E_MID  = 0;    // 7..0
	localparam int E_PORT = 0;    // 5..0
	localparam int W_OP   = 4;

	// any opcode outside this set discards the packet
	typedef enum logic [3:0] {
		ACT_CPU_FIXED = 4'd1,
		ACT_CPU_POLL  = 4'd2,
		ACT_PORT      = 4'd3,
		ACT_SET_MID   = 4'd4
	} act_op_e;

	// register word indexes, wb_adr[9:2] with wb_adr[10] set
	localparam logic [7:0] REG_STATUS   = 8'd1;
	localparam logic [7:0] REG_IN_PKTS  = 8'd3;
	localparam logic [7:0] REG_OUT_PKTS = 8'd9;

endpackage

// File: logic/sync_fifo.sv
// show-ahead synchronous FIFO with an almost-full flag
// the head word is on pop_data whenever empty is low, pop advances it
// with MARK_END set it also tracks how many complete packets are stored

`timescale 1ns/1ps

module sync_fifo #(
	parameter int WIDTH       = 134,
	parameter int DEPTH       = 1024,
	parameter int AFULL_LEVEL = 960,
	parameter bit MARK_END    = 1'b0
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             push,
	input  logic [WIDTH-1:0] push_data,
	input  logic             pop,
	output logic [WIDTH-1:0] pop_data,
	output logic             empty,
	output logic             afull,
	output logic             pkt_avail
);
	import gac_pkg::*;

	localparam int AW = $clog2(DEPTH);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [AW-1:0]    wr_ptr;
	logic [AW-1:0]    rd_ptr;
	logic [AW:0]      count;
	logic             full;

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;   // depth is a power of two
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign pop_data = mem[rd_ptr];
	assign empty    = (count == '0);
	assign full     = (count == (AW+1)'(DEPTH));
	assign afull    = (count >= (AW+1)'(AFULL_LEVEL));

	generate
		if (MARK_END) begin : g_end_cnt
			logic [AW:0] end_cnt;   // stored end-of-packet words
			logic        push_end;
			logic        pop_end;

			assign push_end = push && (push_data[PKT_FLAG_HI:PKT_FLAG_LO] == FLAG_END);
			assign pop_end  = pop && (pop_data[PKT_FLAG_HI:PKT_FLAG_LO] == FLAG_END);

			always_ff @(posedge clk or negedge rst_n) begin
				if (!rst_n)
					end_cnt <= '0;
				else if (push_end && !pop_end)
					end_cnt <= end_cnt + 1'b1;
				else if (pop_end && !push_end)
					end_cnt <= end_cnt - 1'b1;
			end

			assign pkt_avail = (end_cnt != '0);
		end else begin : g_no_end
			assign pkt_avail = 1'b0;
		end
	endgenerate

	// the writer honours afull and the reader honours empty
	a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n) push |-> !full);
	a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n) pop |-> !empty);

endmodule

// File: gac/gac_regs.sv
// register block of the action stage
// Wishbone classic slave for the action table, the packet counters and status
// table entries at wb_adr[10] = 0, registers at wb_adr[10] = 1
// the engine reads the table through a second port with two cycles of latency

`timescale 1ns/1ps

module gac_regs (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                wb_cyc,
	input  logic                wb_stb,
	input  logic                wb_we,
	input  logic [11:0]         wb_adr,
	input  gac_pkg::act_entry_t wb_wdat,
	output gac_pkg::act_entry_t wb_rdat,
	output logic                wb_ack,
	input  logic [7:0]          lookup_index,
	output gac_pkg::act_entry_t lookup_entry,
	input  logic                in_data_wr,
	input  logic                in_word_end,
	input  logic                out_pkt_end,
	input  logic                in_alf,
	input  logic                md_alf,
	input  logic                out_alf
);
	import gac_pkg::*;

	typedef enum logic [1:0] {
		WB_IDLE,
		WB_RD_ADDR,
		WB_RD_DATA,
		WB_DONE
	} wb_state_e;

	wb_state_e  wb_state;
	act_entry_t table_mem [256];
	act_entry_t tbl_rd_q;     // bus side table read
	act_entry_t lk_q;         // engine side, first stage
	act_entry_t reg_rdata;
	act_entry_t status_q;
	logic [31:0] in_pkts;
	logic [31:0] out_pkts;
	logic [7:0]  rd_idx;
	logic        rd_reg;      // read targets the register region
	logic        wb_req;
	logic        tbl_wr;

	assign wb_req = wb_cyc && wb_stb;
	assign tbl_wr = (wb_state == WB_IDLE) && wb_req && wb_we && !wb_adr[10];

	// ************************************************************************
	// action table, one write port and two read ports
	// ************************************************************************
	always_ff @(posedge clk) begin
		if (tbl_wr)
			table_mem[wb_adr[9:2]] <= wb_wdat;
		tbl_rd_q     <= table_mem[rd_idx];
		lk_q         <= table_mem[lookup_index];
		lookup_entry <= lk_q;
	end

	// ************************************************************************
	// bus handshake
	// ************************************************************************
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb_state <= WB_IDLE;
			wb_ack   <= 1'b0;
			rd_idx   <= '0;
			rd_reg   <= 1'b0;
		end else begin
			case (wb_state)
				WB_IDLE: begin
					if (wb_req && wb_we) begin
						wb_ack   <= 1'b1;   // register region writes are dropped
						wb_state <= WB_DONE;
					end else if (wb_req) begin
						rd_idx   <= wb_adr[9:2];
						rd_reg   <= wb_adr[10];
						wb_state <= WB_RD_ADDR;
					end
				end
				WB_RD_ADDR: wb_state <= WB_RD_DATA;   // table read in flight
				WB_RD_DATA: begin
					wb_ack   <= 1'b1;
					wb_state <= WB_DONE;
				end
				WB_DONE: begin
					wb_ack <= 1'b0;
					if (!wb_stb)
						wb_state <= WB_IDLE;   // wait for the master to drop strobe
				end
				default: wb_state <= WB_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (wb_state == WB_RD_DATA)
			wb_rdat <= rd_reg ? reg_rdata : tbl_rd_q;
	end

	always_comb begin
		case (rd_idx)
			REG_STATUS:   reg_rdata = status_q;
			REG_IN_PKTS:  reg_rdata = in_pkts;
			REG_OUT_PKTS: reg_rdata = out_pkts;
			default:      reg_rdata = '0;
		endcase
	end

	// ************************************************************************
	// counters and status
	// ************************************************************************
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			in_pkts  <= '0;
			out_pkts <= '0;
			status_q <= '0;
		end else begin
			if (in_data_wr && in_word_end)
				in_pkts <= in_pkts + 32'd1;
			if (out_pkt_end)
				out_pkts <= out_pkts + 32'd1;
			status_q <= {29'd0, in_alf, md_alf, out_alf};
		end
	end

	// ack is held back until the master strobes, even across a slow master
	a_ack_in_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		wb_ack |-> (wb_cyc && wb_stb));

endmodule

// File: gac/action_engine.sv
// per-packet action engine
// packets for other modules are forwarded untouched, local packets look up
// their action entry and have the first word rebuilt, or are dropped
// output words of one packet leave back to back, one per clock

`timescale 1ns/1ps

module action_engine #(
	parameter gac_pkg::mid_t LOCAL_MID = 8'd4,
	parameter gac_pkg::mid_t NEXT_MID  = 8'd5
) (
	input  logic                clk,
	input  logic                rst_n,
	input  gac_pkg::pkt_word_t  pkt_word,
	input  logic                pkt_avail,
	output logic                pkt_pop,
	input  gac_pkg::md_word_t   md_word,
	input  logic                md_empty,
	output logic                md_pop,
	output logic [7:0]          lookup_index,
	input  gac_pkg::act_entry_t lookup_entry,
	input  gac_pkg::port_t      sys_max_cpuid,
	output gac_pkg::pkt_word_t  out_data,
	output logic                out_data_wr,
	output logic                out_pkt_end,
	input  logic                out_alf
);
	import gac_pkg::*;

	typedef enum logic [2:0] {
		IDLE,
		LOOKUP,
		WAIT,
		HEADER,
		TRANS,
		DISCARD
	} eng_state_e;

	eng_state_e state;
	act_op_e    op;
	pkt_word_t  hdr_word;
	port_t      poll_cpuid;
	port_t      poll_next;
	logic       is_local;
	logic       start_ok;
	logic       word_end;
	logic       drop;

	// first word rebuilt from metadata and table entry
	function automatic pkt_word_t build_header(input pkt_word_t word, input md_word_t meta,
			input act_entry_t entry, input port_t poll);
		pkt_word_t hdr;
		hdr = {word[$bits(pkt_word_t)-1:$bits(md_word_t)], meta};   // keep own flags
		hdr[F_DMID +: W_MID] = NEXT_MID;
		case (act_op_e'(entry[E_OP +: W_OP]))
			ACT_CPU_FIXED: begin
				hdr[F_DES]                  = 1'b1;
				hdr[F_OUTTYPE +: W_OUTTYPE] = 2'd1;
				hdr[F_OUTPORT +: W_PORT]    = entry[E_PORT +: W_PORT];
			end
			ACT_CPU_POLL: begin
				hdr[F_DES]                  = 1'b1;
				hdr[F_OUTTYPE +: W_OUTTYPE] = 2'd2;
				hdr[F_OUTPORT +: W_PORT]    = poll;
			end
			ACT_PORT: begin
				hdr[F_DES]                  = 1'b0;
				hdr[F_OUTTYPE +: W_OUTTYPE] = 2'd0;
				hdr[F_OUTPORT +: W_PORT]    = entry[E_PORT +: W_PORT];
			end
			ACT_SET_MID: begin
				hdr[F_DES]                  = 1'b1;
				hdr[F_OUTTYPE +: W_OUTTYPE] = 2'd0;
				hdr[F_DMID +: W_MID]        = entry[E_MID +: W_MID];
			end
			default: ;
		endcase
		return hdr;
	endfunction

	assign op       = act_op_e'(lookup_entry[E_OP +: W_OP]);
	assign drop     = !(op inside {ACT_CPU_FIXED, ACT_CPU_POLL, ACT_PORT, ACT_SET_MID});
	assign is_local = (md_word[F_DMID +: W_MID] == LOCAL_MID);
	assign start_ok = pkt_avail && !out_alf;   // whole packet stored, room downstream
	assign word_end = (pkt_word[PKT_FLAG_HI:PKT_FLAG_LO] == FLAG_END);
	assign hdr_word = build_header(pkt_word, md_word, lookup_entry, poll_cpuid);

	// round robin wraps before sys_max_cpuid
	assign poll_next = (({1'b0, poll_cpuid} + 7'd1) < {1'b0, sys_max_cpuid}) ?
		poll_cpuid + 6'd1 : '0;

	always_comb begin
		pkt_pop = 1'b0;
		md_pop  = 1'b0;
		case (state)
			LOOKUP: begin
				if (start_ok && !is_local) begin
					pkt_pop = 1'b1;
					md_pop  = 1'b1;
				end
			end
			HEADER: begin
				pkt_pop = 1'b1;
				md_pop  = 1'b1;
			end
			TRANS, DISCARD: pkt_pop = 1'b1;
			default: ;
		endcase
	end

	// ************************************************************************
	// packet FSM
	// ************************************************************************
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state        <= IDLE;
			out_data_wr  <= 1'b0;
			out_pkt_end  <= 1'b0;
			poll_cpuid   <= '0;
			lookup_index <= '0;
		end else begin
			out_data_wr <= 1'b0;
			out_pkt_end <= 1'b0;
			case (state)
				IDLE: begin
					if (!md_empty) begin
						lookup_index <= md_word[F_INDEX +: W_INDEX];
						state        <= LOOKUP;
					end
				end
				LOOKUP: begin
					if (start_ok && is_local) begin
						state <= WAIT;
					end else if (start_ok) begin
						out_data_wr <= 1'b1;      // pass through
						out_pkt_end <= word_end;
						state       <= word_end ? IDLE : TRANS;
					end
				end
				WAIT: state <= HEADER;   // entry leaves the table next cycle
				HEADER: begin
					if (drop) begin
						state <= word_end ? IDLE : DISCARD;
					end else begin
						out_data_wr <= 1'b1;
						out_pkt_end <= word_end;
						state       <= word_end ? IDLE : TRANS;
						if (op == ACT_CPU_POLL)
							poll_cpuid <= poll_next;
					end
				end
				TRANS: begin
					out_data_wr <= 1'b1;
					out_pkt_end <= word_end;
					if (word_end)
						state <= IDLE;
				end
				DISCARD: begin
					if (word_end)
						state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (pkt_pop)
			out_data <= (state == HEADER) ? hdr_word : pkt_word;
	end

	a_end_with_wr: assert property (@(posedge clk) disable iff (!rst_n)
		out_pkt_end |-> out_data_wr);

endmodule

// File: gac/gac_top.sv
// top level of the action stage
// packet words and metadata are buffered in FIFOs, the engine acts on them
// and the register block gives Wishbone access to the table and counters

`timescale 1ns/1ps

module gac_top #(
	parameter gac_pkg::mid_t LOCAL_MID = 8'd4,
	parameter gac_pkg::mid_t NEXT_MID  = 8'd5,
	parameter int            PKT_DEPTH = 1024,
	parameter int            MD_DEPTH  = 256
) (
	input  logic                clk,
	input  logic                rst_n,
	input  gac_pkg::port_t      sys_max_cpuid,
	input  gac_pkg::pkt_word_t  in_data,
	input  logic                in_data_wr,
	output logic                in_alf,
	input  gac_pkg::md_word_t   md,
	input  logic                md_wr,
	output logic                md_alf,
	output gac_pkg::pkt_word_t  out_data,
	output logic                out_data_wr,
	output logic                out_pkt_end,
	input  logic                out_alf,
	input  logic                wb_cyc,
	input  logic                wb_stb,
	input  logic                wb_we,
	input  logic [11:0]         wb_adr,
	input  gac_pkg::act_entry_t wb_wdat,
	output gac_pkg::act_entry_t wb_rdat,
	output logic                wb_ack
);
	import gac_pkg::*;

	// headroom left for words already on their way
	localparam int PKT_AFULL = PKT_DEPTH - 64;
	localparam int MD_AFULL  = MD_DEPTH - 8;

	pkt_word_t  pkt_word;
	md_word_t   md_word;
	act_entry_t lookup_entry;
	logic [7:0] lookup_index;
	logic       pkt_pop;
	logic       pkt_avail;
	logic       md_pop;
	logic       md_empty;

	wire in_word_end = (in_data[PKT_FLAG_HI:PKT_FLAG_LO] == FLAG_END);

	sync_fifo #(
		.WIDTH       ($bits(pkt_word_t)),
		.DEPTH       (PKT_DEPTH),
		.AFULL_LEVEL (PKT_AFULL),
		.MARK_END    (1'b1)
	) pkt_fifo_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.push      (in_data_wr),
		.push_data (in_data),
		.pop       (pkt_pop),
		.pop_data  (pkt_word),
		.empty     (),
		.afull     (in_alf),
		.pkt_avail (pkt_avail)
	);

	sync_fifo #(
		.WIDTH       ($bits(md_word_t)),
		.DEPTH       (MD_DEPTH),
		.AFULL_LEVEL (MD_AFULL),
		.MARK_END    (1'b0)
	) md_fifo_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.push      (md_wr),
		.push_data (md),
		.pop       (md_pop),
		.pop_data  (md_word),
		.empty     (md_empty),
		.afull     (md_alf),
		.pkt_avail ()
	);

	gac_regs regs_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.wb_cyc       (wb_cyc),
		.wb_stb       (wb_stb),
		.wb_we        (wb_we),
		.wb_adr       (wb_adr),
		.wb_wdat      (wb_wdat),
		.wb_rdat      (wb_rdat),
		.wb_ack       (wb_ack),
		.lookup_index (lookup_index),
		.lookup_entry (lookup_entry),
		.in_data_wr   (in_data_wr),
		.in_word_end  (in_word_end),
		.out_pkt_end  (out_pkt_end),
		.in_alf       (in_alf),
		.md_alf       (md_alf),
		.out_alf      (out_alf)
	);

	action_engine #(
		.LOCAL_MID (LOCAL_MID),
		.NEXT_MID  (NEXT_MID)
	) engine_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.pkt_word      (pkt_word),
		.pkt_avail     (pkt_avail),
		.pkt_pop       (pkt_pop),
		.md_word       (md_word),
		.md_empty      (md_empty),
		.md_pop        (md_pop),
		.lookup_index  (lookup_index),
		.lookup_entry  (lookup_entry),
		.sys_max_cpuid (sys_max_cpuid),
		.out_data      (out_data),
		.out_data_wr   (out_data_wr),
		.out_pkt_end   (out_pkt_end),
		.out_alf       (out_alf)
	);

endmodule

// File: dv/tb_clk_gen.sv
// clock source for the testbench
// free running, starts low, period given in ns

`timescale 1ns/1ps

module tb_clk_gen #(
	parameter int PERIOD = 100
) (
	output logic clk
);

	initial clk = 1'b0;

	always #(PERIOD / 2) clk = ~clk;   // even duty cycle

endmodule

// File: dv/gac_tb.sv
// testbench for the action stage
// drives packets, metadata and Wishbone accesses into gac_top and checks
// every output word against a model of the first-word rewrite rules
// inputs change on the falling edge, outputs are sampled there too

`timescale 1ns/1ps

module gac_tb;
	import gac_pkg::*;

	localparam mid_t  LOCAL_MID  = 8'd4;
	localparam mid_t  NEXT_MID   = 8'd5;
	localparam port_t MAX_CPUID  = 6'd3;
	localparam int    WAIT_LIMIT = 2000;   // cycles per wait

	logic        clk;
	logic        rst_n;
	port_t       sys_max_cpuid;
	pkt_word_t   in_data;
	logic        in_data_wr;
	logic        in_alf;
	md_word_t    md;
	logic        md_wr;
	logic        md_alf;
	pkt_word_t   out_data;
	logic        out_data_wr;
	logic        out_pkt_end;
	logic        out_alf;
	logic        wb_cyc;
	logic        wb_stb;
	logic        wb_we;
	logic [11:0] wb_adr;
	act_entry_t  wb_wdat;
	act_entry_t  wb_rdat;
	logic        wb_ack;

	// scoreboard and model state
	pkt_word_t   exp_q[$];
	logic        exp_end_q[$];
	pkt_word_t   exp_word;
	logic        exp_end;
	act_entry_t  model_table [256];
	port_t       poll_model;
	pkt_word_t   pkt_buf [16];
	int          pkt_len;
	int          sent_pkts;
	int          kept_pkts;
	logic        hold_out;   // no output allowed while set

	tb_clk_gen #(.PERIOD(100)) clk_gen_i (.clk(clk));

	gac_top #(
		.LOCAL_MID (LOCAL_MID),
		.NEXT_MID  (NEXT_MID)
	) dut_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.sys_max_cpuid (sys_max_cpuid),
		.in_data       (in_data),
		.in_data_wr    (in_data_wr),
		.in_alf        (in_alf),
		.md            (md),
		.md_wr         (md_wr),
		.md_alf        (md_alf),
		.out_data      (out_data),
		.out_data_wr   (out_data_wr),
		.out_pkt_end   (out_pkt_end),
		.out_alf       (out_alf),
		.wb_cyc        (wb_cyc),
		.wb_stb        (wb_stb),
		.wb_we         (wb_we),
		.wb_adr        (wb_adr),
		.wb_wdat       (wb_wdat),
		.wb_rdat       (wb_rdat),
		.wb_ack        (wb_ack)
	);

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Simulation FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [133:0] got,
			input logic [133:0] exp);
		if (got !== exp)
			fail_run($sformatf("FAIL %s got 0x%0h expected 0x%0h", name, got, exp));
	endtask

	// ************************************************************************
	// reference model
	// ************************************************************************
	function automatic pkt_word_t expect_first_word(input pkt_word_t word,
			input md_word_t meta, input act_entry_t entry, input port_t poll);
		pkt_word_t  w;
		logic [3:0] op;
		logic       des;
		logic [1:0] otype;
		port_t      oport;
		mid_t       dmid;
		op    = entry[E_OP +: W_OP];
		w     = {word[133:128], meta};   // bits above the metadata stay from the word
		des   = 1'b1;
		otype = 2'd0;
		oport = meta[F_OUTPORT +: W_PORT];
		dmid  = NEXT_MID;
		if (op == ACT_CPU_FIXED) begin
			otype = 2'd1;
			oport = entry[E_PORT +: W_PORT];
		end else if (op == ACT_CPU_POLL) begin
			otype = 2'd2;
			oport = poll;
		end else if (op == ACT_PORT) begin
			des   = 1'b0;
			oport = entry[E_PORT +: W_PORT];
		end else begin
			dmid = entry[E_MID +: W_MID];   // outport kept from metadata
		end
		w[F_DES]                  = des;
		w[F_OUTTYPE +: W_OUTTYPE] = otype;
		w[F_OUTPORT +: W_PORT]    = oport;
		w[F_DMID +: W_MID]        = dmid;
		return w;
	endfunction

	function automatic port_t next_poll(input port_t cur);
		if (int'(cur) + 1 >= int'(MAX_CPUID))
			return '0;
		else
			return cur + 6'd1;
	endfunction

	function automatic logic is_action(input logic [3:0] op);
		return (op >= 4'd1) && (op <= 4'd4);
	endfunction

	// ************************************************************************
	// stimulus helpers
	// ************************************************************************
	function automatic pkt_word_t rand_bits();
		pkt_word_t w;
		w[31:0]    = $urandom();
		w[63:32]   = $urandom();
		w[95:64]   = $urandom();
		w[127:96]  = $urandom();
		w[133:128] = 6'($urandom());
		return w;
	endfunction

	function automatic int rand_len();
		return 1 + int'($urandom() % 6);
	endfunction

	function automatic mid_t foreign_mid();
		mid_t m;
		m = 8'($urandom());
		if (m == LOCAL_MID)
			m = NEXT_MID;
		return m;
	endfunction

	function automatic logic [11:0] tbl_adr(input logic [7:0] idx);
		return {2'b00, idx, 2'b00};
	endfunction

	function automatic logic [11:0] reg_adr(input logic [7:0] idx);
		return {2'b01, idx, 2'b00};
	endfunction

	function automatic md_word_t make_meta(input mid_t dmid, input logic [7:0] idx);
		pkt_word_t raw;
		md_word_t  m;
		raw = rand_bits();
		m   = raw[127:0];
		m[F_DMID +: W_MID]    = dmid;
		m[F_INDEX +: W_INDEX] = idx;
		return m;
	endfunction

	task automatic make_packet(input int len);
		int i;
		pkt_len = len;
		for (i = 0; i < len; i++) begin
			pkt_buf[i] = rand_bits();
			if (i == len - 1)
				pkt_buf[i][PKT_FLAG_HI:PKT_FLAG_LO] = FLAG_END;
			else if (i == 0)
				pkt_buf[i][PKT_FLAG_HI:PKT_FLAG_LO] = FLAG_START;
			else
				pkt_buf[i][PKT_FLAG_HI:PKT_FLAG_LO] = 2'b00;
		end
	endtask

	task automatic push_word(input pkt_word_t w, input logic last);
		exp_q.push_back(w);
		exp_end_q.push_back(last);
	endtask

	task automatic queue_expected(input md_word_t meta);
		act_entry_t entry;
		logic [3:0] op;
		int         i;
		sent_pkts++;
		if (meta[F_DMID +: W_MID] != LOCAL_MID) begin
			for (i = 0; i < pkt_len; i++)
				push_word(pkt_buf[i], i == pkt_len - 1);
			kept_pkts++;
		end else begin
			entry = model_table[meta[F_INDEX +: W_INDEX]];
			op    = entry[E_OP +: W_OP];
			if (is_action(op)) begin
				push_word(expect_first_word(pkt_buf[0], meta, entry, poll_model), pkt_len == 1);
				for (i = 1; i < pkt_len; i++)
					push_word(pkt_buf[i], i == pkt_len - 1);
				kept_pkts++;
				if (op == ACT_CPU_POLL)
					poll_model = next_poll(poll_model);
			end
		end
	endtask

	task automatic wait_for_room();
		int n;
		n = 0;
		while ((in_alf || md_alf) && n < WAIT_LIMIT) begin
			in_data_wr = 1'b0;   // hold off while almost full
			md_wr      = 1'b0;
			@(negedge clk);
			n++;
		end
		if (in_alf || md_alf)
			fail_run("input FIFOs stayed almost full");
	endtask

	task automatic drive_packet(input md_word_t meta);
		int i;
		for (i = 0; i < pkt_len; i++) begin
			@(negedge clk);
			wait_for_room();
			in_data    = pkt_buf[i];
			in_data_wr = 1'b1;
			md         = meta;
			md_wr      = (i == 0);   // metadata goes with the first word
		end
		@(negedge clk);
		in_data_wr = 1'b0;
		md_wr      = 1'b0;
	endtask

	task automatic send_packet(input mid_t dmid, input logic [7:0] idx, input int len);
		md_word_t meta;
		make_packet(len);
		meta = make_meta(dmid, idx);
		queue_expected(meta);
		drive_packet(meta);
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (exp_q.size() != 0)
			fail_run("expected packets did not come out in time");
	endtask

	// ************************************************************************
	// Wishbone master
	// ************************************************************************
	task automatic wb_access(input logic we, input logic [11:0] adr,
			input act_entry_t wdat, output act_entry_t rdat);
		int n;
		@(negedge clk);
		wb_cyc  = 1'b1;
		wb_stb  = 1'b1;
		wb_we   = we;
		wb_adr  = adr;
		wb_wdat = wdat;
		n = 0;
		while (!wb_ack && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (!wb_ack)
			fail_run("Wishbone access got no acknowledge");
		rdat = wb_rdat;
		// strobe stays up until the ack pulse is over
		n = 0;
		while (wb_ack && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (wb_ack)
			fail_run("wb_ack did not drop after the access");
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	endtask

	task automatic table_write(input logic [7:0] idx, input act_entry_t val);
		act_entry_t unused_rd;
		wb_access(1'b1, tbl_adr(idx), val, unused_rd);
		model_table[idx] = val;
	endtask

	task automatic read_check(input logic [11:0] adr, input act_entry_t exp,
			input string name);
		act_entry_t got;
		wb_access(1'b0, adr, '0, got);
		check_value(name, 134'(got), 134'(exp));
	endtask

	task automatic check_counters();
		read_check(reg_adr(REG_IN_PKTS), 32'(sent_pkts), "in_pkts");
		read_check(reg_adr(REG_OUT_PKTS), 32'(kept_pkts), "out_pkts");
	endtask

	// output monitor, compares in arrival order
	always @(negedge clk) begin
		if (rst_n && out_data_wr) begin
			if (hold_out)
				fail_run("output word appeared while out_alf was high");
			else if (exp_q.size() == 0)
				fail_run("output word appeared with no packet expected");
			else begin
				exp_word = exp_q.pop_front();
				exp_end  = exp_end_q.pop_front();
				check_value("out_data", out_data, exp_word);
				check_value("out_pkt_end", 134'(out_pkt_end), 134'(exp_end));
			end
		end
	end

	initial begin
		int         i;
		logic [3:0] op;
		void'($urandom(59608));
		rst_n         = 1'b0;
		sys_max_cpuid = MAX_CPUID;
		in_data       = '0;
		in_data_wr    = 1'b0;
		md            = '0;
		md_wr         = 1'b0;
		out_alf       = 1'b0;
		wb_cyc        = 1'b0;
		wb_stb        = 1'b0;
		wb_we         = 1'b0;
		wb_adr        = '0;
		wb_wdat       = '0;
		hold_out      = 1'b0;
		poll_model    = '0;
		sent_pkts     = 0;
		kept_pkts     = 0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		// flow control flags out of reset
		check_value("in_alf", 134'(in_alf), 134'(0));
		check_value("md_alf", 134'(md_alf), 134'(0));

		// table read back, idle status, counters out of reset
		check_counters();
		for (i = 0; i < 32; i++)
			table_write(8'(i), $urandom());
		for (i = 0; i < 32; i++)
			read_check(tbl_adr(8'(i)), model_table[i], "table entry");
		read_check(reg_adr(REG_STATUS), '0, "status");

		// packets for other modules
		for (i = 0; i < 4; i++)
			send_packet(foreign_mid(), 8'($urandom()), rand_len());
		wait_drain();

		// local rewrites
		for (i = 0; i < 12; i++) begin
			case ($urandom() % 3)
				0:       op = ACT_CPU_FIXED;
				1:       op = ACT_PORT;
				default: op = ACT_SET_MID;
			endcase
			table_write(8'(8'h40 + i), {op, 28'($urandom())});
			send_packet(LOCAL_MID, 8'(8'h40 + i), rand_len());
		end
		wait_drain();

		// round robin over cpu threads 0..2
		table_write(8'h60, {4'(ACT_CPU_POLL), 28'($urandom())});
		for (i = 0; i < 7; i++) begin
			check_value("poll_model", 134'(poll_model), 134'(i % 3));
			send_packet(LOCAL_MID, 8'h60, rand_len());
		end
		wait_drain();

		// discard, then a forwarded packet behind it
		table_write(8'h70, {4'h0, 28'($urandom())});
		send_packet(LOCAL_MID, 8'h70, rand_len());
		send_packet(foreign_mid(), 8'($urandom()), rand_len());
		wait_drain();
		check_counters();

		// ********************************************************************
		// downstream back-pressure
		// ********************************************************************
		@(negedge clk);
		out_alf  = 1'b1;
		hold_out = 1'b1;
		send_packet(LOCAL_MID, 8'h41, rand_len());
		send_packet(foreign_mid(), 8'($urandom()), rand_len());
		send_packet(LOCAL_MID, 8'h60, rand_len());
		repeat (20) @(negedge clk);
		read_check(reg_adr(REG_STATUS), 32'h1, "status");
		@(negedge clk);
		out_alf  = 1'b0;
		hold_out = 1'b0;
		wait_drain();
		check_counters();

		// stray words after the drain are caught by the monitor
		repeat (4) @(negedge clk);
		$display("Simulation PASSED");
		$finish;
	end

endmodule

// File: sources.f
common/gac_pkg.sv
logic/sync_fifo.sv
gac/gac_regs.sv
gac/action_engine.sv
gac/gac_top.sv
dv/tb_clk_gen.sv
dv/gac_tb.sv

// File: Makefile
# Verilator build and run of the action stage testbench

TOP := gac_tb
OBJ := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f sources.f \
		--top-module $(TOP) -Mdir $(OBJ) -o V$(TOP)
	./$(OBJ)/V$(TOP)

clean:
	rm -rf $(OBJ)
